/* tb.f */
verilog/dma_axi_pkg.sv
verilog/dma_backend_pkg.sv
verilog/dma_burst_splitter.sv
verilog/dma_data_buffer.sv
verilog/dma_write_tracker.sv
verilog/synth_dma_backend.sv
verif/tb_axi_mem_model.sv
verif/tb_synth_dma_backend.sv

/* verif/tb_axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem_model #(
    parameter int unsigned                       MemWords = 4096,
    parameter logic [dma_axi_pkg::AddrWidth-1:0] ErrBase  = 32'h0000_3000,
    parameter int unsigned                       StallPct = 30,
    parameter logic [31:0]                       Seed     = 32'd12098
) (
    input  logic                              clk_i,
    input  logic                              rst_n_i,

    input  logic [dma_axi_pkg::AddrWidth-1:0] ar_addr_i,
    input  dma_axi_pkg::len_t                 ar_len_i,
    input  logic                              ar_valid_i,
    output logic                              ar_ready_o,

    output logic [dma_axi_pkg::DataWidth-1:0] r_data_o,
    output logic                              r_last_o,
    output logic                              r_valid_o,
    input  logic                              r_ready_i,

    input  logic [dma_axi_pkg::AddrWidth-1:0] aw_addr_i,
    input  dma_axi_pkg::len_t                 aw_len_i,
    input  logic                              aw_valid_i,
    output logic                              aw_ready_o,

    input  logic [dma_axi_pkg::DataWidth-1:0] w_data_i,
    input  logic                              w_valid_i,
    output logic                              w_ready_o,

    output dma_axi_pkg::resp_e                b_resp_o,
    output logic                              b_valid_o,
    input  logic                              b_ready_i
);

    import dma_axi_pkg::*;

    logic [DataWidth-1:0] mem [MemWords];
    logic [31:0]          rng_q;

    logic [AddrWidth-1:0] ar_addr_q [$];
    len_t                 ar_len_q [$];
    logic [AddrWidth-1:0] aw_addr_q [$];
    len_t                 aw_len_q [$];
    resp_e                b_q [$];        // Responses waiting for the B channel.

    logic [AddrWidth-1:0] rd_addr;
    logic [AddrWidth-1:0] wr_addr;
    int unsigned          rd_left;
    int unsigned          wr_left;
    logic                 rd_busy;
    logic                 wr_busy;
    resp_e                wr_resp;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Advances the generator and says whether this channel may move now.
    function automatic logic roll_ready();
        rng_q = xorshift32(rng_q);
        return (rng_q % 100) >= StallPct;
    endfunction

    initial begin
        rng_q      = Seed;
        ar_ready_o = 1'b0;
        aw_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        r_valid_o  = 1'b0;
        r_last_o   = 1'b0;
        r_data_o   = '0;
        b_valid_o  = 1'b0;
        b_resp_o   = RESP_OKAY;
        for (int i = 0; i < MemWords; i++) begin
            rng_q  = xorshift32(rng_q);
            mem[i] = rng_q ^ (i << 2);      // Mixes in the byte address.
        end
    end

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            ar_ready_o <= 1'b0;
            aw_ready_o <= 1'b0;
            w_ready_o  <= 1'b0;
            r_valid_o  <= 1'b0;
            b_valid_o  <= 1'b0;
            rd_busy = 1'b0;
            wr_busy = 1'b0;
            ar_addr_q.delete();
            ar_len_q.delete();
            aw_addr_q.delete();
            aw_len_q.delete();
            b_q.delete();
        end else begin
            if (ar_valid_i && ar_ready_o) begin
                ar_addr_q.push_back(ar_addr_i);
                ar_len_q.push_back(ar_len_i);
            end
            if (aw_valid_i && aw_ready_o) begin
                aw_addr_q.push_back(aw_addr_i);
                aw_len_q.push_back(aw_len_i);
            end
            ar_ready_o <= roll_ready();
            aw_ready_o <= roll_ready();

            // Read bursts are served one after the other.
            if (r_valid_o && r_ready_i) begin
                rd_addr = rd_addr + BytesPerBeat;
                rd_left = rd_left - 1;
                if (rd_left == 0) rd_busy = 1'b0;
            end
            if (!r_valid_o || r_ready_i) begin
                r_valid_o <= 1'b0;
                if (!rd_busy && ar_addr_q.size() > 0) begin
                    rd_addr = ar_addr_q.pop_front();
                    rd_left = ar_len_q.pop_front() + 1;
                    rd_busy = 1'b1;
                end
                if (rd_busy && roll_ready()) begin
                    r_valid_o <= 1'b1;
                    r_data_o  <= mem[rd_addr / BytesPerBeat];
                    r_last_o  <= (rd_left == 1);
                end
            end

            if (w_valid_i && w_ready_o) begin
                mem[wr_addr / BytesPerBeat] = w_data_i;
                wr_addr = wr_addr + BytesPerBeat;
                wr_left = wr_left - 1;
                if (wr_left == 0) begin
                    b_q.push_back(wr_resp);
                    wr_busy = 1'b0;
                end
            end
            if (!wr_busy && aw_addr_q.size() > 0) begin
                wr_addr = aw_addr_q.pop_front();
                wr_left = aw_len_q.pop_front() + 1;
                wr_resp = (wr_addr >= ErrBase) ? RESP_SLVERR : RESP_OKAY;
                wr_busy = 1'b1;
            end
            w_ready_o <= wr_busy && roll_ready();   // Data waits for its AW.

            if (b_valid_o && b_ready_i) b_valid_o <= 1'b0;
            if ((!b_valid_o || b_ready_i) && b_q.size() > 0 && roll_ready()) begin
                b_valid_o <= 1'b1;
                b_resp_o  <= b_q.pop_front();
            end
        end
    end

endmodule : tb_axi_mem_model

`default_nettype wire

/* verif/tb_synth_dma_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_synth_dma_backend;

    import dma_axi_pkg::*;
    import dma_backend_pkg::*;

    localparam int unsigned    MemWords = 4096;
    localparam logic [31:0]    ErrBase  = 32'h0000_3000;
    localparam int unsigned    StallPct = 30;
    localparam logic [31:0]    Seed     = 32'd12098;
    localparam int unsigned    NumTrans = 7;

    // Source, destination, byte count and expected error of each transfer.
    logic [31:0] tab_src   [NumTrans] = '{32'h0000, 32'h0FF8, 32'h0100, 32'h0FFC,
                                          32'h0200, 32'h1100, 32'h0304};
    logic [31:0] tab_dst   [NumTrans] = '{32'h1800, 32'h1900, 32'h1FF4, 32'h2100,
                                          32'h3000, 32'h2200, 32'h2304};
    logic [31:0] tab_bytes [NumTrans] = '{4, 52, 40, 8, 24, 28, 20};
    logic        tab_err   [NumTrans] = '{0, 0, 0, 0, 1, 0, 0};

    logic                 clk_i = 1'b0;
    logic                 rst_n_i;
    logic [AddrWidth-1:0] req_src_i;
    logic [AddrWidth-1:0] req_dst_i;
    logic [AddrWidth-1:0] req_num_bytes_i;
    logic                 req_valid_i;
    logic                 req_ready_o;
    logic [AddrWidth-1:0] ar_addr_o;
    len_t                 ar_len_o;
    logic                 ar_valid_o;
    logic                 ar_ready_i;
    logic [DataWidth-1:0] r_data_i;
    logic                 r_last_i;
    logic                 r_valid_i;
    logic                 r_ready_o;
    logic [AddrWidth-1:0] aw_addr_o;
    len_t                 aw_len_o;
    logic                 aw_valid_o;
    logic                 aw_ready_i;
    logic [DataWidth-1:0] w_data_o;
    logic                 w_last_o;
    logic                 w_valid_o;
    logic                 w_ready_i;
    resp_e                b_resp_i;
    logic                 b_valid_i;
    logic                 b_ready_o;
    logic                 backend_idle_o;
    logic                 trans_complete_o;
    logic                 trans_error_o;

    logic [31:0]  ref_mem [MemWords];
    len_t         ar_lens [$];
    len_t         aw_lens [$];
    len_t         w_lens [$];       // Write bursts still owed W beats.
    int unsigned  ar_sum = 0;
    int unsigned  ar_trans = 0;
    int unsigned  w_beat = 0;
    int unsigned  r_level = 0;      // Beats held between R and W.
    int unsigned  b_level = 0;      // Issued bursts still waiting for B.
    int unsigned  comp_idx = 0;
    int unsigned  cycles = 0;
    int unsigned  cycle_limit = 0;

    synth_dma_backend UUT (.*);

    tb_axi_mem_model #(
        .MemWords ( MemWords ),
        .ErrBase  ( ErrBase  ),
        .StallPct ( StallPct ),
        .Seed     ( Seed     )
    ) i_mem_model (
        .clk_i      ( clk_i      ), .rst_n_i    ( rst_n_i    ),
        .ar_addr_i  ( ar_addr_o  ), .ar_len_i   ( ar_len_o   ),
        .ar_valid_i ( ar_valid_o ), .ar_ready_o ( ar_ready_i ),
        .r_data_o   ( r_data_i   ), .r_last_o   ( r_last_i   ),
        .r_valid_o  ( r_valid_i  ), .r_ready_i  ( r_ready_o  ),
        .aw_addr_i  ( aw_addr_o  ), .aw_len_i   ( aw_len_o   ),
        .aw_valid_i ( aw_valid_o ), .aw_ready_o ( aw_ready_i ),
        .w_data_i   ( w_data_o   ),
        .w_valid_i  ( w_valid_o  ), .w_ready_o  ( w_ready_i  ),
        .b_resp_o   ( b_resp_i   ), .b_valid_o  ( b_valid_i  ),
        .b_ready_i  ( b_ready_o  )
    );

    always #50 clk_i = ~clk_i;

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "Value mismatch.");
        end
    endtask

    function automatic logic crosses_page(input logic [31:0] addr, input len_t len);
        return (addr % PageBytes) + (len + 1) * BytesPerBeat > PageBytes;
    endfunction

    // Burst shape, flow control, W last and completion order.
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            check_equal("r_ready_o", r_ready_o, r_level != BufferDepth);
            check_equal("b_ready_o", b_ready_o, b_level != 0);
            if (r_valid_i && r_ready_o) r_level = r_level + 1;
            if (w_valid_o && w_ready_i) r_level = r_level - 1;
            if (ar_valid_o && ar_ready_i) begin
                check_equal("ar_len_o within MaxBeats", ar_len_o < MaxBeats, 1);
                check_equal("ar_addr_o crosses page", crosses_page(ar_addr_o, ar_len_o), 0);
                check_equal("ar burst beyond table", ar_trans < NumTrans, 1);
                ar_lens.push_back(ar_len_o);
                ar_sum = ar_sum + ar_len_o + 1;
                if (ar_sum >= tab_bytes[ar_trans] / BytesPerBeat) begin
                    check_equal("read beats of transfer", ar_sum,
                                tab_bytes[ar_trans] / BytesPerBeat);
                    ar_sum = 0;
                    ar_trans <= ar_trans + 1;
                end
            end
            if (aw_valid_o && aw_ready_i) begin
                check_equal("aw_len_o within MaxBeats", aw_len_o < MaxBeats, 1);
                check_equal("aw_addr_o crosses page", crosses_page(aw_addr_o, aw_len_o), 0);
                aw_lens.push_back(aw_len_o);
                w_lens.push_back(aw_len_o);
            end
            while (ar_lens.size() > 0 && aw_lens.size() > 0) begin
                check_equal("aw_len_o against ar_len_o", aw_lens.pop_front(), ar_lens.pop_front());
                b_level = b_level + 1;
            end
            if (b_valid_i && b_ready_o) b_level = b_level - 1;
            if (w_valid_o && w_ready_i) begin
                check_equal("w_last_o", w_last_o, w_beat == w_lens[0]);
                if (w_beat == w_lens[0]) begin
                    void'(w_lens.pop_front());
                    w_beat = 0;
                end else begin
                    w_beat = w_beat + 1;
                end
            end
            if (trans_complete_o) begin
                check_equal("trans_complete_o count", comp_idx < NumTrans, 1);
                check_equal("trans_error_o", trans_error_o, tab_err[comp_idx]);
                comp_idx <= comp_idx + 1;
            end
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the transfers did not finish within %0d cycles.", cycle_limit);
            $display("STATUS: FAIL");
            $fatal(1, "Run stopped by timeout.");
        end
    end

    initial begin
        rst_n_i         = 1'b0;
        req_valid_i     = 1'b0;
        req_src_i       = '0;
        req_dst_i       = '0;
        req_num_bytes_i = '0;
        cycle_limit     = 200;
        for (int i = 0; i < NumTrans; i++) begin
            cycle_limit = cycle_limit + tab_bytes[i] / BytesPerBeat * 40;
        end

        repeat (4) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);
        check_equal("req_ready_o", req_ready_o, 1);
        check_equal("backend_idle_o", backend_idle_o, 1);
        check_equal("ar_valid_o", ar_valid_o, 0);
        check_equal("aw_valid_o", aw_valid_o, 0);
        check_equal("w_valid_o", w_valid_o, 0);
        check_equal("trans_complete_o", trans_complete_o, 0);
        for (int i = 0; i < MemWords; i++) begin
            ref_mem[i] = i_mem_model.mem[i];
        end

        for (int i = 0; i < NumTrans; i++) begin
            @(posedge clk_i);
            req_src_i       <= tab_src[i];
            req_dst_i       <= tab_dst[i];
            req_num_bytes_i <= tab_bytes[i];
            req_valid_i     <= 1'b1;
            do @(posedge clk_i); while (!req_ready_o);
            req_valid_i <= 1'b0;
            for (int w = 0; w < tab_bytes[i] / BytesPerBeat; w++) begin
                ref_mem[tab_dst[i] / BytesPerBeat + w] = ref_mem[tab_src[i] / BytesPerBeat + w];
            end
        end

        while (comp_idx != NumTrans) @(posedge clk_i);
        repeat (2) @(posedge clk_i);
        check_equal("req_ready_o", req_ready_o, 1);
        check_equal("backend_idle_o", backend_idle_o, 1);
        check_equal("transfers issued", ar_trans, NumTrans);
        check_equal("unmatched ar bursts", ar_lens.size(), 0);
        check_equal("unmatched aw bursts", aw_lens.size(), 0);
        check_equal("write bursts without data", w_lens.size(), 0);
        for (int i = 0; i < MemWords; i++) begin
            check_equal($sformatf("mem word at 0x%04h", i * BytesPerBeat),
                        i_mem_model.mem[i], ref_mem[i]);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule : tb_synth_dma_backend

`default_nettype wire

/* verilog/dma_axi_pkg.sv */
`default_nettype none

package dma_axi_pkg;

    // Bus widths.
    localparam int unsigned AddrWidth    = 32;
    localparam int unsigned DataWidth    = 32;
    localparam int unsigned BytesPerBeat = DataWidth / 8;

    // Bursts must not cross this boundary.
    localparam int unsigned PageBytes    = 4096;

    // AXI length field holds beats minus one.
    typedef logic [7:0] len_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

endpackage : dma_axi_pkg

`default_nettype wire

/* verilog/dma_backend_pkg.sv */
`default_nettype none

package dma_backend_pkg;

    // Longest burst the splitter issues.
    localparam int unsigned MaxBeats       = 4;

    // Read to write beat FIFO.
    localparam int unsigned BufferDepth    = 8;

    // Bursts that may wait for their B response.
    localparam int unsigned MaxOutstanding = 4;

    typedef enum logic {
        SPLIT_IDLE  = 1'b0,
        SPLIT_ISSUE = 1'b1
    } split_state_e;

endpackage : dma_backend_pkg

`default_nettype wire

/* verilog/dma_burst_splitter.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_burst_splitter (
    input  logic                              clk_i,
    input  logic                              rst_n_i,

    input  logic [dma_axi_pkg::AddrWidth-1:0] req_src_i,
    input  logic [dma_axi_pkg::AddrWidth-1:0] req_dst_i,
    input  logic [dma_axi_pkg::AddrWidth-1:0] req_num_bytes_i,
    input  logic                              req_valid_i,
    output logic                              req_ready_o,

    output logic [dma_axi_pkg::AddrWidth-1:0] ar_addr_o,
    output dma_axi_pkg::len_t                 ar_len_o,
    output logic                              ar_valid_o,
    input  logic                              ar_ready_i,

    output logic [dma_axi_pkg::AddrWidth-1:0] aw_addr_o,
    output dma_axi_pkg::len_t                 aw_len_o,
    output logic                              aw_valid_o,
    input  logic                              aw_ready_i,

    input  logic                              tracker_full_i,
    output logic                              burst_push_o,
    output logic                              push_last_o,
    output logic                              busy_o
);

    import dma_axi_pkg::*;
    import dma_backend_pkg::*;

    split_state_e           state_q;
    logic                   ar_valid_q;
    logic                   aw_valid_q;
    logic                   inflight_q;     // Current burst not yet fully accepted.

    logic [AddrWidth-1:0]   src_q;
    logic [AddrWidth-1:0]   dst_q;
    logic [AddrWidth-1:0]   words_q;

    logic [AddrWidth-1:0]   src_room;
    logic [AddrWidth-1:0]   dst_room;
    logic [AddrWidth-1:0]   beats;
    logic [AddrWidth-1:0]   step_bytes;
    logic                   last_burst;
    logic                   req_fire;
    logic                   ar_fire;
    logic                   aw_fire;
    logic                   burst_done;
    logic                   launch;

    // Words left before each side reaches a page boundary.
    assign src_room = AddrWidth'((PageBytes - (src_q & (PageBytes - 1))) / BytesPerBeat);
    assign dst_room = AddrWidth'((PageBytes - (dst_q & (PageBytes - 1))) / BytesPerBeat);

    always_comb begin
        beats = AddrWidth'(MaxBeats);
        if (words_q < beats) beats = words_q;
        if (src_room < beats) beats = src_room;
        if (dst_room < beats) beats = dst_room;
    end

    assign step_bytes = AddrWidth'(beats * BytesPerBeat);
    assign last_burst = (words_q == beats);

    assign req_fire   = req_valid_i & req_ready_o;
    assign ar_fire    = ar_valid_q & ar_ready_i;
    assign aw_fire    = aw_valid_q & aw_ready_i;

    // Both commands of the burst are through once neither valid is left pending.
    assign burst_done = inflight_q & (~ar_valid_q | ar_ready_i) & (~aw_valid_q | aw_ready_i);

    assign launch = ~tracker_full_i & (req_fire
                                       | ((state_q == SPLIT_ISSUE) & ~inflight_q)
                                       | (burst_done & ~last_burst));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= SPLIT_IDLE;
            ar_valid_q <= 1'b0;
            aw_valid_q <= 1'b0;
            inflight_q <= 1'b0;
        end else begin
            if (req_fire) begin
                state_q <= SPLIT_ISSUE;
            end else if (burst_done && last_burst) begin
                state_q <= SPLIT_IDLE;
            end

            if (launch) begin
                ar_valid_q <= 1'b1;
                aw_valid_q <= 1'b1;
                inflight_q <= 1'b1;
            end else begin
                if (ar_fire) ar_valid_q <= 1'b0;
                if (aw_fire) aw_valid_q <= 1'b0;
                if (burst_done) inflight_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            src_q   <= req_src_i;
            dst_q   <= req_dst_i;
            words_q <= AddrWidth'(req_num_bytes_i / BytesPerBeat);
        end else if (burst_done) begin
            src_q   <= src_q + step_bytes;
            dst_q   <= dst_q + step_bytes;
            words_q <= words_q - beats;
        end
    end

    assign req_ready_o  = (state_q == SPLIT_IDLE);
    assign busy_o       = (state_q == SPLIT_ISSUE);

    assign ar_addr_o    = src_q;
    assign aw_addr_o    = dst_q;
    assign ar_len_o     = len_t'(beats - 1'b1);
    assign aw_len_o     = len_t'(beats - 1'b1);
    assign ar_valid_o   = ar_valid_q;
    assign aw_valid_o   = aw_valid_q;

    assign burst_push_o = burst_done;
    assign push_last_o  = last_burst;   // Qualified by burst_push_o.

endmodule : dma_burst_splitter

`default_nettype wire

/* verilog/dma_data_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_data_buffer (
    input  logic                              clk_i,
    input  logic                              rst_n_i,

    input  logic [dma_axi_pkg::DataWidth-1:0] r_data_i,
    input  logic                              r_last_i,
    input  logic                              r_valid_i,
    output logic                              r_ready_o,

    output logic [dma_axi_pkg::DataWidth-1:0] w_data_o,
    output logic                              w_last_o,
    output logic                              w_valid_o,
    input  logic                              w_ready_i,

    output logic                              empty_o
);

    import dma_axi_pkg::*;
    import dma_backend_pkg::*;

    logic [DataWidth-1:0]               data_q [BufferDepth];
    logic                               last_q [BufferDepth];

    logic [$clog2(BufferDepth)-1:0]     wr_ptr_q;
    logic [$clog2(BufferDepth)-1:0]     rd_ptr_q;
    logic [$clog2(BufferDepth+1)-1:0]   count_q;

    logic                               push;
    logic                               pop;

    assign push = r_valid_i & r_ready_o;
    assign pop  = w_valid_o & w_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;   // Depth is a power of two.
            if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            data_q[wr_ptr_q] <= r_data_i;
            last_q[wr_ptr_q] <= r_last_i;
        end
    end

    assign r_ready_o = (count_q != BufferDepth);
    assign w_valid_o = (count_q != '0);
    assign w_data_o  = data_q[rd_ptr_q];
    assign w_last_o  = last_q[rd_ptr_q];
    assign empty_o   = (count_q == '0);

endmodule : dma_data_buffer

`default_nettype wire

/* verilog/dma_write_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_write_tracker (
    input  logic               clk_i,
    input  logic               rst_n_i,

    input  logic               burst_push_i,
    input  logic               push_last_i,
    output logic               full_o,

    input  dma_axi_pkg::resp_e b_resp_i,
    input  logic               b_valid_i,
    output logic               b_ready_o,

    output logic               trans_complete_o,
    output logic               trans_error_o,
    output logic               empty_o
);

    import dma_axi_pkg::*;
    import dma_backend_pkg::*;

    logic                                 last_flag_q [MaxOutstanding];
    logic [$clog2(MaxOutstanding)-1:0]    wr_ptr_q;
    logic [$clog2(MaxOutstanding)-1:0]    rd_ptr_q;
    logic [$clog2(MaxOutstanding+1)-1:0]  count_q;

    logic   err_acc_q;      // Sticky error of the transfer being answered.
    logic   complete_q;
    logic   error_q;
    logic   b_fire;
    logic   err_next;

    assign b_fire   = b_valid_i & b_ready_o;
    assign err_next = err_acc_q | (b_resp_i != RESP_OKAY);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            err_acc_q  <= 1'b0;
            complete_q <= 1'b0;
            error_q    <= 1'b0;
        end else begin
            complete_q <= 1'b0;
            if (burst_push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (b_fire) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
                if (last_flag_q[rd_ptr_q]) begin
                    complete_q <= 1'b1;
                    error_q    <= err_next;
                    err_acc_q  <= 1'b0;
                end else begin
                    err_acc_q  <= err_next;
                end
            end
            case ({burst_push_i, b_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (burst_push_i) last_flag_q[wr_ptr_q] <= push_last_i;
    end

    // One slot stays free for the burst the splitter may still have in flight.
    assign full_o           = (count_q >= MaxOutstanding - 1);
    assign b_ready_o        = (count_q != '0);
    assign empty_o          = (count_q == '0);
    assign trans_complete_o = complete_q;
    assign trans_error_o    = error_q;

endmodule : dma_write_tracker

`default_nettype wire

/* verilog/synth_dma_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module synth_dma_backend (
    input  logic                              clk_i,
    input  logic                              rst_n_i,

    input  logic [dma_axi_pkg::AddrWidth-1:0] req_src_i,
    input  logic [dma_axi_pkg::AddrWidth-1:0] req_dst_i,
    input  logic [dma_axi_pkg::AddrWidth-1:0] req_num_bytes_i,
    input  logic                              req_valid_i,
    output logic                              req_ready_o,

    output logic [dma_axi_pkg::AddrWidth-1:0] ar_addr_o,
    output dma_axi_pkg::len_t                 ar_len_o,
    output logic                              ar_valid_o,
    input  logic                              ar_ready_i,

    input  logic [dma_axi_pkg::DataWidth-1:0] r_data_i,
    input  logic                              r_last_i,
    input  logic                              r_valid_i,
    output logic                              r_ready_o,

    output logic [dma_axi_pkg::AddrWidth-1:0] aw_addr_o,
    output dma_axi_pkg::len_t                 aw_len_o,
    output logic                              aw_valid_o,
    input  logic                              aw_ready_i,

    output logic [dma_axi_pkg::DataWidth-1:0] w_data_o,
    output logic                              w_last_o,
    output logic                              w_valid_o,
    input  logic                              w_ready_i,

    input  dma_axi_pkg::resp_e                b_resp_i,
    input  logic                              b_valid_i,
    output logic                              b_ready_o,

    output logic                              backend_idle_o,
    output logic                              trans_complete_o,
    output logic                              trans_error_o
);

    logic burst_push;
    logic push_last;
    logic tracker_full;
    logic splitter_busy;
    logic buffer_empty;
    logic tracker_empty;

    dma_burst_splitter i_splitter (
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .req_src_i       ( req_src_i       ),
        .req_dst_i       ( req_dst_i       ),
        .req_num_bytes_i ( req_num_bytes_i ),
        .req_valid_i     ( req_valid_i     ),
        .req_ready_o     ( req_ready_o     ),
        .ar_addr_o       ( ar_addr_o       ),
        .ar_len_o        ( ar_len_o        ),
        .ar_valid_o      ( ar_valid_o      ),
        .ar_ready_i      ( ar_ready_i      ),
        .aw_addr_o       ( aw_addr_o       ),
        .aw_len_o        ( aw_len_o        ),
        .aw_valid_o      ( aw_valid_o      ),
        .aw_ready_i      ( aw_ready_i      ),
        .tracker_full_i  ( tracker_full    ),
        .burst_push_o    ( burst_push      ),
        .push_last_o     ( push_last       ),
        .busy_o          ( splitter_busy   )
    );

    dma_data_buffer i_buffer (
        .clk_i     ( clk_i        ),
        .rst_n_i   ( rst_n_i      ),
        .r_data_i  ( r_data_i     ),
        .r_last_i  ( r_last_i     ),
        .r_valid_i ( r_valid_i    ),
        .r_ready_o ( r_ready_o    ),
        .w_data_o  ( w_data_o     ),
        .w_last_o  ( w_last_o     ),
        .w_valid_o ( w_valid_o    ),
        .w_ready_i ( w_ready_i    ),
        .empty_o   ( buffer_empty )
    );

    dma_write_tracker i_tracker (
        .clk_i            ( clk_i            ),
        .rst_n_i          ( rst_n_i          ),
        .burst_push_i     ( burst_push       ),
        .push_last_i      ( push_last        ),
        .full_o           ( tracker_full     ),
        .b_resp_i         ( b_resp_i         ),
        .b_valid_i        ( b_valid_i        ),
        .b_ready_o        ( b_ready_o        ),
        .trans_complete_o ( trans_complete_o ),
        .trans_error_o    ( trans_error_o    ),
        .empty_o          ( tracker_empty    )
    );

    // Idle only when nothing is queued anywhere in the backend.
    assign backend_idle_o = ~splitter_busy & buffer_empty & tracker_empty;

endmodule : synth_dma_backend

`default_nettype wire
